//--- Makefile
# Verilator build and run of the long-multiply unit testbench

VERILATOR ?= verilator
TOP       ?= mul_unit_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/mul_unit_checker.sv
// Shared array arbiter checker
// Grant legality and round-robin alternation between lanes,
// bound into every shared array instance

`timescale 1ns/100ps
`include "mul_macros.svh"

module mul_unit_checker #(
        parameter int NUM_LANES = `MUL_NUM_LANES
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic [NUM_LANES-1:0]    i_pp_valid,
        input  logic [NUM_LANES-1:0]    i_pp_grant
);

////////////////////////////////////////////////////////////

// At most one lane owns the multiplier
a_grant_onehot0: assert property (@(posedge i_clk) disable iff (i_reset)
        $onehot0(i_pp_grant))
        else $error("Grant is not one-hot or zero");

// No grant without a request
a_grant_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_pp_grant & ~i_pp_valid) == '0)
        else $error("Grant given to a lane that is not requesting");

// Work conserving
a_grant_any: assert property (@(posedge i_clk) disable iff (i_reset)
        (|i_pp_valid) |-> (|i_pp_grant))
        else $error("Requests pending but no lane granted");

// All lanes asking twice in a row, winner must change
a_grant_rotate: assert property (@(posedge i_clk) disable iff (i_reset)
        ((&i_pp_valid) && $past(&i_pp_valid)) |-> (i_pp_grant != $past(i_pp_grant)))
        else $error("Same lane granted twice while all lanes request");

endmodule

bind mul_shared_array mul_unit_checker #(
        .NUM_LANES (NUM_LANES)
) u_checker (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_pp_valid (i_pp_valid),
        .i_pp_grant (o_pp_grant)
);

//--- dv/mul_unit_tb.sv
// Long-multiply unit testbench
// Table of lane requests with stall, flush and restart
// options, checked against a 64-bit reference model

`timescale 1ns/100ps
`include "mul_macros.svh"

module mul_unit_tb
        import mul_pkg::*;
();

////////////////////////////////////////////////////////////

localparam int NL      = `MUL_NUM_LANES;
localparam int TIMEOUT = 40;
// Quiet cycles watched after the last done
localparam int WATCH   = 8;

// One table entry, stall and flush start two cycles in
typedef struct packed {
        logic [NL-1:0]          mask;
        mul_req_t [NL-1:0]      req;
        logic [3:0]             stall_len;
        logic                   flush;
        logic                   restart;
} row_t;

logic                   i_clk;
logic                   i_reset;
logic                   i_stall;
logic                   i_flush;
logic [NL-1:0]          i_start;
mul_req_t               i_req [NL];
logic [NL-1:0]          o_busy;
logic [NL-1:0]          o_done;
mul_rsp_t               o_rsp [NL];

row_t                   rows [$];
// Model of each lane's last low word
logic [31:0]            last_low [NL];

mul_unit_top UUT (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .i_start (i_start),
        .i_req   (i_req),
        .o_busy  (o_busy),
        .o_done  (o_done),
        .o_rsp   (o_rsp)
);

// 100 ns clock
initial
begin
        i_clk = 1'b0;
        forever
                #50 i_clk = ~i_clk;
end

////////////////////////////////////////////////////////////
// Helpers
////////////////////////////////////////////////////////////

task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped on error");
endtask

task automatic check(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp)
        begin
                $display("[FAIL] t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
                stop_with_failure();
        end
endtask

function automatic mul_req_t make_req(mul_op_e op, logic [31:0] rm, logic [31:0] rs,
                                      logic [31:0] rn, logic [31:0] rh);
        mul_req_t r;
        r.op = op;
        r.rm = rm;
        r.rs = rs;
        r.rn = rn;
        r.rh = rh;
        return r;
endfunction

// Random op and operands, addend on about half
function automatic mul_req_t random_req();
        mul_req_t r;
        logic     with_add;
        with_add = 1'($urandom_range(1, 0));
        r.op     = mul_op_e'($urandom_range(3, 0));
        r.rm     = $urandom();
        r.rs     = $urandom();
        r.rn     = with_add ? $urandom() : 32'd0;
        r.rh     = with_add ? $urandom() : 32'd0;
        return r;
endfunction

// Full 64-bit result, operands extended per bit 1 of op
function automatic logic [63:0] ref_total(mul_req_t r);
        logic [63:0] a;
        logic [63:0] b;
        a = r.op[1] ? {{32{r.rm[31]}}, r.rm} : {32'd0, r.rm};
        b = r.op[1] ? {{32{r.rs[31]}}, r.rs} : {32'd0, r.rs};
        return a * b + {r.rh, r.rn};
endfunction

task automatic add_row(logic [NL-1:0] mask, mul_req_t r0, mul_req_t r1, int stall,
                       logic flush, logic restart);
        row_t row;
        row.mask      = mask;
        row.req[0]    = r0;
        row.req[1]    = r1;
        row.stall_len = 4'(stall);
        row.flush     = flush;
        row.restart   = restart;
        rows.push_back(row);
endtask

////////////////////////////////////////////////////////////
// Stimulus table
////////////////////////////////////////////////////////////

task automatic build_rows();
        mul_req_t nil;
        nil = '0;
        // Lane 0 alone, low then high, plain and with addend
        add_row(2'b01, make_req(MUL_OP_UMULL_LO, 32'hffff_ffff, 32'hffff_ffff, 0, 0), nil, 0, 0, 0);
        add_row(2'b01, make_req(MUL_OP_UMULL_HI, 32'hffff_ffff, 32'hffff_ffff, 0, 0), nil, 0, 0, 0);
        add_row(2'b01, make_req(MUL_OP_SMULL_LO, 32'hffff_fffd, 32'd7, 32'h10, 32'h1), nil, 0, 0, 0);
        add_row(2'b01, make_req(MUL_OP_SMULL_HI, 32'h8000_0000, 32'h8000_0000,
                                32'h1234_5678, 32'h0abc_def0), nil, 0, 0, 0);
        // Lane 1 history starts empty, then a zero low word
        add_row(2'b10, nil, make_req(MUL_OP_SMULL_HI, 32'h7fff_ffff, 32'h8000_0001, 0, 0), 0, 0, 0);
        add_row(2'b10, nil, make_req(MUL_OP_UMULL_LO, 32'h0001_0000, 32'h0001_0000, 0, 0), 0, 0, 0);
        add_row(2'b10, nil, make_req(MUL_OP_UMULL_HI, 32'h0001_0000, 32'h0001_0000, 0, 0), 0, 0, 0);
        // Both lanes at once
        for (int i = 0; i < 3; i++)
                add_row(2'b11, random_req(), random_req(), 0, 0, 0);
        // Stall mid-operation
        add_row(2'b01, random_req(), nil, 4, 0, 0);
        add_row(2'b10, nil, random_req(), 2, 0, 0);
        // Nonzero low word, flushed request, then a high word
        add_row(2'b01, make_req(MUL_OP_UMULL_LO, 32'd3, 32'd5, 0, 0), nil, 0, 0, 0);
        add_row(2'b01, random_req(), nil, 0, 1, 0);
        add_row(2'b01, make_req(MUL_OP_UMULL_HI, 32'hffff_ffff, 32'd2, 0, 0), nil, 0, 0, 0);
        // Second start while busy
        add_row(2'b10, nil, random_req(), 0, 0, 1);
        add_row(2'b01, random_req(), nil, 0, 0, 1);
        // Random mix of lanes and ops
        for (int i = 0; i < 12; i++)
                add_row(NL'($urandom_range(3, 1)), random_req(), random_req(), 0, 0, 0);
endtask

////////////////////////////////////////////////////////////
// Row execution
////////////////////////////////////////////////////////////

// Outputs sampled on the falling edge before new inputs go out
task automatic run_row(int idx, row_t r);
        logic [NL-1:0]  pending;
        mul_rsp_t       exp_rsp [NL];
        logic [63:0]    total;
        int             cycles;
        int             quiet;
        string          lane;
        for (int l = 0; l < NL; l++)
        begin
                total             = ref_total(r.req[l]);
                exp_rsp[l].rd     = r.req[l].op[0] ? total[63:32] : total[31:0];
                exp_rsp[l].nozero = r.req[l].op[0] && (last_low[l] != 32'd0);
        end
        @(negedge i_clk);
        i_start = r.mask;
        for (int l = 0; l < NL; l++)
                i_req[l] = r.req[l];
        pending = r.flush ? '0 : r.mask;
        cycles  = 0;
        quiet   = 0;
        while (quiet < WATCH)
        begin
                @(negedge i_clk);
                cycles++;
                if (cycles == 1)
                        check($sformatf("row %0d o_busy", idx), o_busy, r.mask);
                for (int l = 0; l < NL; l++)
                begin
                        lane = $sformatf("row %0d lane %0d", idx, l);
                        if (o_done[l] && !pending[l])
                        begin
                                $display("Unexpected done on %s at %0t", lane, $time);
                                stop_with_failure();
                        end
                        if (o_done[l])
                        begin
                                check({lane, " o_rsp.rd"}, o_rsp[l].rd, exp_rsp[l].rd);
                                check({lane, " o_rsp.nozero"}, o_rsp[l].nozero,
                                      exp_rsp[l].nozero);
                                // Fixed latency only with no competing lane
                                if ($onehot(r.mask))
                                        check({lane, " done latency"}, cycles, 5 + r.stall_len);
                                if (!r.req[l].op[0])
                                        last_low[l] = exp_rsp[l].rd;
                                pending[l] = 1'b0;
                        end
                end
                // Flush idles every lane and wipes its history
                if (r.flush && cycles == 3)
                begin
                        check($sformatf("row %0d o_busy after flush", idx), o_busy, 64'd0);
                        for (int l = 0; l < NL; l++)
                                last_low[l] = 32'd0;
                end
                if (pending != '0 && cycles >= TIMEOUT)
                begin
                        $display("Timed out waiting for done in row %0d at %0t", idx, $time);
                        stop_with_failure();
                end
                if (pending == '0)
                        quiet++;
                // Next cycle inputs
                i_start = '0;
                if (r.restart && cycles == 2)
                begin
                        i_start = r.mask;
                        for (int l = 0; l < NL; l++)
                                i_req[l].rm = ~r.req[l].rm;
                end
                if (r.stall_len != 0 && cycles == 2)
                        i_stall = 1'b1;
                if (cycles == 2 + r.stall_len)
                        i_stall = 1'b0;
                i_flush = r.flush && (cycles == 2);
        end
endtask

initial
begin
        void'($urandom(32'h166e_acf2));
        i_reset = 1'b1;
        i_stall = 1'b0;
        i_flush = 1'b0;
        i_start = '0;
        for (int l = 0; l < NL; l++)
        begin
                i_req[l]    = '0;
                last_low[l] = 32'd0;
        end
        build_rows();
        repeat (3) @(negedge i_clk);
        i_reset = 1'b0;
        check("o_busy after reset", o_busy, 64'd0);
        check("o_done after reset", o_done, 64'd0);
        foreach (rows[i])
                run_row(i, rows[i]);
        $display("ALL CHECKS PASSED");
        $finish;
end

endmodule

//--- filelist.f
+incdir+include
rtl/mul_pkg.sv
rtl/mul_sequencer.sv
rtl/mul_shared_array.sv
rtl/mul_unit_top.sv
dv/mul_unit_checker.sv
dv/mul_unit_tb.sv

//--- include/mul_macros.svh
// Long-multiply sizing constants
// Lane count for the shared array and width of one
// partial-product operand

`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

////////////////////////////////////////////////////////////

// Peer lanes sharing the multiplier array
`define MUL_NUM_LANES 2

// One 17-bit signed operand of the array
// Holds a 16-bit half plus a sign or zero extension bit
`define MUL_PP_WIDTH 17

////////////////////////////////////////////////////////////

`endif

//--- rtl/mul_pkg.sv
// Long-multiply types
// Opcodes, sequencer states, lane request and response,
// and the operand pair sent to the shared array

`include "mul_macros.svh"

package mul_pkg;

        ////////////////////////////////////////////////////////////

        // Bit 0 picks the high word, bit 1 picks signed
        typedef enum logic [1:0] {
                MUL_OP_UMULL_LO = 2'b00,
                MUL_OP_UMULL_HI = 2'b01,
                MUL_OP_SMULL_LO = 2'b10,
                MUL_OP_SMULL_HI = 2'b11
        } mul_op_e;

        // One state per partial product, then the addend step
        typedef enum logic [2:0] {
                ST_IDLE   = 3'd0,
                ST_PP_LL  = 3'd1,
                ST_PP_HL  = 3'd2,
                ST_PP_LH  = 3'd3,
                ST_PP_HH  = 3'd4,
                ST_FINISH = 3'd5
        } mul_state_e;

        ////////////////////////////////////////////////////////////

        // rm * rs + {rh, rn}, addend zero for a plain multiply
        typedef struct packed {
                mul_op_e     op;
                logic [31:0] rm;
                logic [31:0] rs;
                logic [31:0] rn;
                logic [31:0] rh;
        } mul_req_t;

        // Result word plus the zero-flag hint
        typedef struct packed {
                logic [31:0] rd;
                logic        nozero;
        } mul_rsp_t;

        // Operand pair for one 17x17 signed product
        typedef struct packed {
                logic signed [`MUL_PP_WIDTH-1:0] a;
                logic signed [`MUL_PP_WIDTH-1:0] b;
        } pp_req_t;

endpackage

//--- rtl/mul_sequencer.sv
// Long-multiply lane sequencer
// Builds a 32x32 product from four 17x17 partial products
// taken from the shared array, adds the 64-bit addend and
// returns the low or high word with the zero-flag hint

`timescale 1ns/100ps
`include "mul_macros.svh"

module mul_sequencer
        import mul_pkg::*;
(
        input  logic                                i_clk,
        input  logic                                i_reset,
        input  logic                                i_stall,
        input  logic                                i_flush,

        // Lane request side
        input  logic                                i_start,
        input  mul_req_t                            i_req,

        // Shared array side
        output logic                                o_pp_valid,
        output pp_req_t                             o_pp,
        input  logic                                i_pp_grant,
        input  logic signed [2*`MUL_PP_WIDTH-1:0]   i_pp_product,

        // Lane response side
        output logic                                o_busy,
        output logic                                o_done,
        output mul_rsp_t                            o_rsp
);

////////////////////////////////////////////////////////////

mul_state_e                       state_q;
mul_state_e                       state_d;
mul_req_t                         req_q;
logic signed [63:0]               acc_q;
logic signed [63:0]               acc_d;
logic [31:0]                      low_hist_q;

logic                             accept;
logic                             step;
logic                             pp_state;
logic                             is_signed;
logic                             is_high;
logic signed [63:0]               pp_ext;
logic [63:0]                      total;

// Operand halves, each 17 bits
logic signed [`MUL_PP_WIDTH-1:0]  rm_hi;
logic signed [`MUL_PP_WIDTH-1:0]  rs_hi;
logic signed [`MUL_PP_WIDTH-1:0]  rm_lo;
logic signed [`MUL_PP_WIDTH-1:0]  rs_lo;

////////////////////////////////////////////////////////////
// Operand split
////////////////////////////////////////////////////////////

assign is_signed = req_q.op[1];
assign is_high   = req_q.op[0];

// Upper halves carry the sign only for signed ops
assign rm_hi = is_signed ? {req_q.rm[31], req_q.rm[31:16]} : {1'b0, req_q.rm[31:16]};
assign rs_hi = is_signed ? {req_q.rs[31], req_q.rs[31:16]} : {1'b0, req_q.rs[31:16]};

// Lower halves are always positive
assign rm_lo = {1'b0, req_q.rm[15:0]};
assign rs_lo = {1'b0, req_q.rs[15:0]};

////////////////////////////////////////////////////////////
// Array handshake
////////////////////////////////////////////////////////////

assign pp_state = (state_q == ST_PP_LL) || (state_q == ST_PP_HL) ||
                  (state_q == ST_PP_LH) || (state_q == ST_PP_HH);

// Stall and flush withdraw the request
assign o_pp_valid = pp_state & ~i_stall & ~i_flush;

// Advance only on a granted cycle
assign step = o_pp_valid & i_pp_grant;

// New work only from idle
assign accept = (state_q == ST_IDLE) & i_start & ~i_stall & ~i_flush;

// Sign-extend the 34-bit product to accumulator width
assign pp_ext = i_pp_product;

// Operand pair per step
always_comb
begin
        o_pp = '0;
        case (state_q)
                ST_PP_LL:
                begin
                        o_pp.a = rm_lo;
                        o_pp.b = rs_lo;
                end
                ST_PP_HL:
                begin
                        o_pp.a = rs_hi;
                        o_pp.b = rm_lo;
                end
                ST_PP_LH:
                begin
                        o_pp.a = rm_hi;
                        o_pp.b = rs_lo;
                end
                ST_PP_HH:
                begin
                        o_pp.a = rm_hi;
                        o_pp.b = rs_hi;
                end
                default:
                begin
                        o_pp = '0;
                end
        endcase
end

////////////////////////////////////////////////////////////
// Next state and accumulate
////////////////////////////////////////////////////////////

always_comb
begin
        state_d = state_q;
        acc_d   = acc_q;
        case (state_q)
                ST_IDLE:
                begin
                        // Fresh accumulator for each request
                        acc_d = '0;
                        if (accept)
                                state_d = ST_PP_LL;
                end
                ST_PP_LL:
                begin
                        if (step)
                        begin
                                acc_d   = acc_q + pp_ext;
                                state_d = ST_PP_HL;
                        end
                end
                ST_PP_HL:
                begin
                        if (step)
                        begin
                                acc_d   = acc_q + (pp_ext <<< 16);
                                state_d = ST_PP_LH;
                        end
                end
                ST_PP_LH:
                begin
                        if (step)
                        begin
                                acc_d   = acc_q + (pp_ext <<< 16);
                                state_d = ST_PP_HH;
                        end
                end
                ST_PP_HH:
                begin
                        if (step)
                        begin
                                acc_d   = acc_q + (pp_ext <<< 32);
                                state_d = ST_FINISH;
                        end
                end
                default:
                begin
                        // Finish lasts one unstalled cycle
                        state_d = ST_IDLE;
                end
        endcase
end

////////////////////////////////////////////////////////////
// Result
////////////////////////////////////////////////////////////

// Product plus {rh, rn}
assign total = acc_q + {req_q.rh, req_q.rn};

assign o_busy = (state_q != ST_IDLE);
assign o_done = (state_q == ST_FINISH) & ~i_stall & ~i_flush;

always_comb
begin
        o_rsp = '0;
        if (o_done)
        begin
                o_rsp.rd     = is_high ? total[63:32] : total[31:0];
                // Hint only on a high word after a nonzero low word
                o_rsp.nozero = is_high & (low_hist_q != 32'd0);
        end
end

////////////////////////////////////////////////////////////
// Registers
////////////////////////////////////////////////////////////

// Flush wins over stall
always_ff @(posedge i_clk)
begin
        if (i_reset || i_flush)
        begin
                state_q    <= ST_IDLE;
                acc_q      <= '0;
                low_hist_q <= '0;
        end
        else if (!i_stall)
        begin
                state_q <= state_d;
                acc_q   <= acc_d;
                // Remember the last low word
                if (o_done && !is_high)
                        low_hist_q <= total[31:0];
        end
end

// Request held for the whole operation
always_ff @(posedge i_clk)
begin
        if (accept)
                req_q <= i_req;
end

endmodule

//--- rtl/mul_shared_array.sv
// Shared 17x17 multiplier array
// Round-robin arbiter picks one requesting lane per cycle and
// feeds its operands to a single signed multiplier, product
// goes to every lane and only the granted lane consumes it

`timescale 1ns/100ps
`include "mul_macros.svh"

module mul_shared_array
        import mul_pkg::*;
#(
        parameter int NUM_LANES = `MUL_NUM_LANES
)
(
        input  logic                                i_clk,
        input  logic                                i_reset,

        // Lane requests
        input  logic [NUM_LANES-1:0]                i_pp_valid,
        input  pp_req_t                             i_pp [NUM_LANES],

        // One-hot grant and broadcast product
        output logic [NUM_LANES-1:0]                o_pp_grant,
        output logic signed [2*`MUL_PP_WIDTH-1:0]   o_pp_product
);

////////////////////////////////////////////////////////////

localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

// Most recently granted lane
logic [PTR_W-1:0]                 last_q;

logic [PTR_W-1:0]                 win_idx;
logic                             win_found;

// Operands of the winning lane
logic signed [`MUL_PP_WIDTH-1:0]  op_a;
logic signed [`MUL_PP_WIDTH-1:0]  op_b;

////////////////////////////////////////////////////////////
// Round-robin pick
////////////////////////////////////////////////////////////

// Search starts at the lane after the last winner
always_comb
begin : pick
        int cand;
        cand      = 0;
        win_idx   = last_q;
        win_found = 1'b0;
        for (int off = 1; off <= NUM_LANES; off++)
        begin
                cand = (int'(last_q) + off) % NUM_LANES;
                if (!win_found && i_pp_valid[cand])
                begin
                        win_found = 1'b1;
                        win_idx   = PTR_W'(cand);
                end
        end
end

always_comb
begin
        o_pp_grant = '0;
        if (win_found)
                o_pp_grant[win_idx] = 1'b1;
end

// Pointer moves only when someone is granted
always_ff @(posedge i_clk)
begin
        if (i_reset)
                // Lane 0 wins first
                last_q <= PTR_W'(NUM_LANES - 1);
        else if (win_found)
                last_q <= win_idx;
end

////////////////////////////////////////////////////////////
// Multiplier
////////////////////////////////////////////////////////////

// Idle array sees zero operands
assign op_a = win_found ? i_pp[win_idx].a : '0;
assign op_b = win_found ? i_pp[win_idx].b : '0;

// Single 17x17 signed product, same cycle
assign o_pp_product = op_a * op_b;

endmodule

//--- rtl/mul_unit_top.sv
// Long-multiply unit top
// Per-lane sequencers sharing one 17x17 multiplier array,
// no extra register stage between lanes and array

`timescale 1ns/100ps
`include "mul_macros.svh"

module mul_unit_top
        import mul_pkg::*;
(
        input  logic                                i_clk,
        input  logic                                i_reset,
        input  logic                                i_stall,
        input  logic                                i_flush,

        // Per-lane requests
        input  logic [`MUL_NUM_LANES-1:0]           i_start,
        input  mul_req_t                            i_req [`MUL_NUM_LANES],

        // Per-lane status and results
        output logic [`MUL_NUM_LANES-1:0]           o_busy,
        output logic [`MUL_NUM_LANES-1:0]           o_done,
        output mul_rsp_t                            o_rsp [`MUL_NUM_LANES]
);

////////////////////////////////////////////////////////////

// Lane to array request path
logic [`MUL_NUM_LANES-1:0]                 pp_valid;
pp_req_t                                   pp_req [`MUL_NUM_LANES];

// Array to lane return path
logic [`MUL_NUM_LANES-1:0]                 pp_grant;
logic signed [2*`MUL_PP_WIDTH-1:0]         pp_product;

////////////////////////////////////////////////////////////
// Lanes
////////////////////////////////////////////////////////////

for (genvar g = 0; g < `MUL_NUM_LANES; g++)
begin : g_lane
        mul_sequencer u_seq (
                .i_clk        (i_clk),
                .i_reset      (i_reset),
                .i_stall      (i_stall),
                .i_flush      (i_flush),
                .i_start      (i_start[g]),
                .i_req        (i_req[g]),
                .o_pp_valid   (pp_valid[g]),
                .o_pp         (pp_req[g]),
                .i_pp_grant   (pp_grant[g]),
                .i_pp_product (pp_product),
                .o_busy       (o_busy[g]),
                .o_done       (o_done[g]),
                .o_rsp        (o_rsp[g])
        );
end

////////////////////////////////////////////////////////////
// Shared array
////////////////////////////////////////////////////////////

mul_shared_array #(
        .NUM_LANES (`MUL_NUM_LANES)
) u_array (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_pp_valid   (pp_valid),
        .i_pp         (pp_req),
        .o_pp_grant   (pp_grant),
        .o_pp_product (pp_product)
);

endmodule
